// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= udp_cmd_top.f
RTL_TOP   ?= udp_cmd_top
TB_TOP    ?= tb_udp_cmd
BUILD_DIR ?= obj_dir
LINT_OPTS ?= --lint-only --timing
SIM_OPTS  ?= --binary --timing
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_OPTS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/cmd_decode.sv ====
`timescale 1ns/1ps

module cmd_decode (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [udp_cmd_pkg::IP_W-1:0]     local_ip,
    input  logic                             rx_hdr_valid,
    output logic                             rx_hdr_ready,
    input  logic [udp_cmd_pkg::IP_W-1:0]     rx_src_ip,
    input  logic [udp_cmd_pkg::PORT_W-1:0]   rx_src_port,
    input  logic [udp_cmd_pkg::PORT_W-1:0]   rx_dest_port,
    input  logic [udp_cmd_pkg::PORT_W-1:0]   rx_length,
    cmd_if.source                            cmd
);

    logic                 full;
    logic                 full_next;
    udp_cmd_pkg::cmd_op_t op_next;

    always_comb begin
        case (rx_dest_port)
            udp_cmd_pkg::PORT_ECHO,
            udp_cmd_pkg::PORT_ECHO_FIXED: op_next = udp_cmd_pkg::op_echo;
            udp_cmd_pkg::PORT_RD_REQ:     op_next = udp_cmd_pkg::op_read;
            default:                      op_next = udp_cmd_pkg::op_none;
        endcase
    end

    // One-entry slot, filled on the header handshake
    assign full_next = (rx_hdr_valid && rx_hdr_ready) || (full && !cmd.ready);
    assign cmd.valid = full;

    always_ff @(posedge clk) begin
        if (rst) begin
            full         <= 1'b0;
            rx_hdr_ready <= 1'b0;
        end else begin
            full         <= full_next;
            rx_hdr_ready <= !full_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_hdr_valid && rx_hdr_ready) begin
            cmd.op      <= op_next;
            cmd.src_ip  <= local_ip;
            cmd.dest_ip <= rx_src_ip;
            if (op_next == udp_cmd_pkg::op_read) begin
                cmd.src_port  <= udp_cmd_pkg::PORT_RD_REQ;
                cmd.dest_port <= udp_cmd_pkg::PORT_RD_REPLY;
                cmd.length    <= udp_cmd_pkg::READ_LEN + udp_cmd_pkg::HDR_LEN;
            end else begin
                cmd.src_port <= udp_cmd_pkg::PORT_ECHO;
                // Port 68 always answers to the echo port
                cmd.dest_port <= (rx_dest_port == udp_cmd_pkg::PORT_ECHO) ?
                                 rx_src_port : udp_cmd_pkg::PORT_ECHO;
                cmd.length    <= rx_length;
            end
        end
    end

endmodule

// ==== hdl/cmd_execute.sv ====
`timescale 1ns/1ps

module cmd_execute (
    input  logic                                  clk,
    input  logic                                  rst,
    cmd_if.sink                                   cmd,
    input  logic [udp_cmd_pkg::BYTE_W-1:0]        rx_tdata,
    input  logic                                  rx_tvalid,
    input  logic                                  rx_tlast,
    output logic                                  rx_tready,
    output logic                                  wb_cyc,
    output logic                                  wb_stb,
    output logic [udp_cmd_pkg::FLASH_ADR_W-1:0]   wb_adr,
    input  logic [udp_cmd_pkg::BYTE_W-1:0]        wb_dat_i,
    input  logic                                  wb_ack,
    reply_if.source                               reply
);

    udp_cmd_pkg::exec_state_t               state;
    logic [udp_cmd_pkg::FLASH_ADR_W-1:0]    rd_addr;
    logic [1:0]                             addr_cnt;
    logic                                   read_pend;
    logic [udp_cmd_pkg::RD_CNT_W-1:0]       rd_cnt;
    logic                                   rd_valid;
    logic                                   rd_last;
    logic [udp_cmd_pkg::BYTE_W-1:0]         rd_data;
    logic                                   hdr_valid;
    logic [udp_cmd_pkg::IP_W-1:0]           hdr_src_ip;
    logic [udp_cmd_pkg::IP_W-1:0]           hdr_dest_ip;
    logic [udp_cmd_pkg::PORT_W-1:0]         hdr_src_port;
    logic [udp_cmd_pkg::PORT_W-1:0]         hdr_dest_port;
    logic [udp_cmd_pkg::PORT_W-1:0]         hdr_length;
    logic                                   rx_xfer;
    logic                                   out_xfer;

    // A pending header blocks the next command
    assign cmd.ready = (state == udp_cmd_pkg::st_idle) && !hdr_valid;

    always_comb begin
        case (state)
            udp_cmd_pkg::st_echo:  rx_tready = reply.ready;
            udp_cmd_pkg::st_addr,
            udp_cmd_pkg::st_drain: rx_tready = 1'b1;
            default:               rx_tready = 1'b0;
        endcase
    end

    assign rx_xfer  = rx_tvalid && rx_tready;
    assign out_xfer = reply.valid && reply.ready;

    assign reply.hdr_valid = hdr_valid;
    assign reply.src_ip    = hdr_src_ip;
    assign reply.dest_ip   = hdr_dest_ip;
    assign reply.src_port  = hdr_src_port;
    assign reply.dest_port = hdr_dest_port;
    assign reply.length    = hdr_length;

    // Echo passes rx bytes straight on, read offers the fetched byte
    assign reply.valid = (state == udp_cmd_pkg::st_echo) ? rx_tvalid : rd_valid;
    assign reply.data  = (state == udp_cmd_pkg::st_echo) ? rx_tdata : rd_data;
    assign reply.last  = (state == udp_cmd_pkg::st_echo) ? rx_tlast : rd_last;

    assign wb_stb = wb_cyc;
    assign wb_adr = rd_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= udp_cmd_pkg::st_idle;
            hdr_valid <= 1'b0;
            addr_cnt  <= 2'd0;
            read_pend <= 1'b0;
            rd_cnt    <= '0;
            rd_valid  <= 1'b0;
            wb_cyc    <= 1'b0;
        end else begin
            if (reply.hdr_valid && reply.hdr_ready) begin
                hdr_valid <= 1'b0;
            end
            case (state)
                udp_cmd_pkg::st_idle: begin
                    if (cmd.valid && cmd.ready) begin
                        read_pend <= 1'b0;
                        addr_cnt  <= 2'd0;
                        case (cmd.op)
                            udp_cmd_pkg::op_echo: begin
                                state     <= udp_cmd_pkg::st_echo;
                                hdr_valid <= 1'b1;
                            end
                            udp_cmd_pkg::op_read: state <= udp_cmd_pkg::st_addr;
                            default:              state <= udp_cmd_pkg::st_drain;
                        endcase
                    end
                end
                udp_cmd_pkg::st_echo: begin
                    if (rx_xfer && rx_tlast) begin
                        state <= udp_cmd_pkg::st_idle;
                    end
                end
                udp_cmd_pkg::st_addr: begin
                    if (rx_xfer) begin
                        addr_cnt <= addr_cnt + 2'd1;
                        if (rx_tlast) begin
                            state     <= udp_cmd_pkg::st_read;
                            hdr_valid <= 1'b1;
                            rd_cnt    <= '0;
                        end else if (addr_cnt == 2'd2) begin
                            state     <= udp_cmd_pkg::st_drain;
                            read_pend <= 1'b1;
                        end
                    end
                end
                udp_cmd_pkg::st_drain: begin
                    if (rx_xfer && rx_tlast) begin
                        read_pend <= 1'b0;
                        if (read_pend) begin
                            state     <= udp_cmd_pkg::st_read;
                            hdr_valid <= 1'b1;
                            rd_cnt    <= '0;
                        end else begin
                            state <= udp_cmd_pkg::st_idle;
                        end
                    end
                end
                udp_cmd_pkg::st_read: begin
                    if (wb_cyc && wb_ack) begin
                        wb_cyc   <= 1'b0;
                        rd_valid <= 1'b1;
                        rd_cnt   <= rd_cnt + 1'b1;
                    end else if (!wb_cyc && !rd_valid && reply.ready) begin
                        // Next fetch only while the reply path moves
                        wb_cyc <= 1'b1;
                    end
                    if (out_xfer) begin
                        rd_valid <= 1'b0;
                        if (rd_last) begin
                            state <= udp_cmd_pkg::st_idle;
                        end
                    end
                end
                default: state <= udp_cmd_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == udp_cmd_pkg::st_idle && cmd.valid && cmd.ready) begin
            rd_addr       <= '0;
            hdr_src_ip    <= cmd.src_ip;
            hdr_dest_ip   <= cmd.dest_ip;
            hdr_src_port  <= cmd.src_port;
            hdr_dest_port <= cmd.dest_port;
            hdr_length    <= cmd.length;
        end else if (state == udp_cmd_pkg::st_addr && rx_xfer) begin
            // Address arrives least significant byte first
            rd_addr <= {rx_tdata, rd_addr[udp_cmd_pkg::FLASH_ADR_W-1:udp_cmd_pkg::BYTE_W]};
        end else if (wb_cyc && wb_ack) begin
            rd_addr <= rd_addr + 1'b1;
        end
        if (wb_cyc && wb_ack) begin
            rd_data <= wb_dat_i;
            rd_last <= (rd_cnt == udp_cmd_pkg::RD_LAST);
        end
    end

endmodule

// ==== hdl/reply_result.sv ====
`timescale 1ns/1ps

module reply_result (
    input  logic                             clk,
    input  logic                             rst,
    reply_if.sink                            reply,
    output logic                             tx_hdr_valid,
    input  logic                             tx_hdr_ready,
    output logic [udp_cmd_pkg::IP_W-1:0]     tx_src_ip,
    output logic [udp_cmd_pkg::IP_W-1:0]     tx_dest_ip,
    output logic [udp_cmd_pkg::PORT_W-1:0]   tx_src_port,
    output logic [udp_cmd_pkg::PORT_W-1:0]   tx_dest_port,
    output logic [udp_cmd_pkg::PORT_W-1:0]   tx_length,
    output logic [udp_cmd_pkg::BYTE_W-1:0]   tx_tdata,
    output logic                             tx_tvalid,
    input  logic                             tx_tready,
    output logic                             tx_tlast
);

    logic hdr_load;
    logic data_load;

    // Each register takes a new item when empty or emptying this cycle
    assign reply.hdr_ready = !tx_hdr_valid || tx_hdr_ready;
    assign reply.ready     = !tx_tvalid || tx_tready;

    assign hdr_load  = reply.hdr_valid && reply.hdr_ready;
    assign data_load = reply.valid && reply.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
            tx_tvalid    <= 1'b0;
        end else begin
            if (hdr_load) begin
                tx_hdr_valid <= 1'b1;
            end else if (tx_hdr_ready) begin
                tx_hdr_valid <= 1'b0;
            end
            if (data_load) begin
                tx_tvalid <= 1'b1;
            end else if (tx_tready) begin
                tx_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_load) begin
            tx_src_ip    <= reply.src_ip;
            tx_dest_ip   <= reply.dest_ip;
            tx_src_port  <= reply.src_port;
            tx_dest_port <= reply.dest_port;
            tx_length    <= reply.length;
        end
        if (data_load) begin
            tx_tdata <= reply.data;
            tx_tlast <= reply.last;
        end
    end

endmodule

// ==== hdl/udp_cmd_if.sv ====
`timescale 1ns/1ps

// Decoded command with its reply header
interface cmd_if;
    logic                             valid;
    logic                             ready;
    udp_cmd_pkg::cmd_op_t             op;
    logic [udp_cmd_pkg::IP_W-1:0]     src_ip;
    logic [udp_cmd_pkg::IP_W-1:0]     dest_ip;
    logic [udp_cmd_pkg::PORT_W-1:0]   src_port;
    logic [udp_cmd_pkg::PORT_W-1:0]   dest_port;
    logic [udp_cmd_pkg::PORT_W-1:0]   length;

    modport source (output valid, op, src_ip, dest_ip, src_port, dest_port, length,
                    input ready);
    modport sink (input valid, op, src_ip, dest_ip, src_port, dest_port, length,
                  output ready);
endinterface

// Reply header channel plus payload byte channel
interface reply_if;
    logic                             hdr_valid;
    logic                             hdr_ready;
    logic [udp_cmd_pkg::IP_W-1:0]     src_ip;
    logic [udp_cmd_pkg::IP_W-1:0]     dest_ip;
    logic [udp_cmd_pkg::PORT_W-1:0]   src_port;
    logic [udp_cmd_pkg::PORT_W-1:0]   dest_port;
    logic [udp_cmd_pkg::PORT_W-1:0]   length;
    logic [udp_cmd_pkg::BYTE_W-1:0]   data;
    logic                             valid;
    logic                             ready;
    logic                             last;

    modport source (output hdr_valid, src_ip, dest_ip, src_port, dest_port, length,
                    output data, valid, last, input hdr_ready, ready);
    modport sink (input hdr_valid, src_ip, dest_ip, src_port, dest_port, length,
                  input data, valid, last, output hdr_ready, ready);
endinterface

// ==== hdl/udp_cmd_pkg.sv ====
package udp_cmd_pkg;

    localparam int IP_W        = 32;
    localparam int PORT_W      = 16;
    localparam int BYTE_W      = 8;
    localparam int FLASH_ADR_W = 24;

    // UDP header size and bytes returned per flash read
    localparam logic [PORT_W-1:0] HDR_LEN  = 16'd8;
    localparam logic [PORT_W-1:0] READ_LEN = 16'd16;

    // Read byte counter
    localparam int RD_CNT_W = $clog2(READ_LEN);
    localparam logic [RD_CNT_W-1:0] RD_LAST = RD_CNT_W'(READ_LEN - 16'd1);

    localparam logic [PORT_W-1:0] PORT_ECHO       = 16'd1234;
    localparam logic [PORT_W-1:0] PORT_ECHO_FIXED = 16'd68;
    localparam logic [PORT_W-1:0] PORT_RD_REQ     = 16'heee0;
    localparam logic [PORT_W-1:0] PORT_RD_REPLY   = 16'heee1;

    typedef enum logic [1:0] {
        op_none,
        op_echo,
        op_read
    } cmd_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_echo,
        st_addr,
        st_drain,
        st_read
    } exec_state_t;

endpackage

// ==== hdl/udp_cmd_top.sv ====
`timescale 1ns/1ps

module udp_cmd_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [udp_cmd_pkg::IP_W-1:0]          local_ip,
    input  logic                                  rx_hdr_valid,
    output logic                                  rx_hdr_ready,
    input  logic [udp_cmd_pkg::IP_W-1:0]          rx_src_ip,
    input  logic [udp_cmd_pkg::PORT_W-1:0]        rx_src_port,
    input  logic [udp_cmd_pkg::PORT_W-1:0]        rx_dest_port,
    input  logic [udp_cmd_pkg::PORT_W-1:0]        rx_length,
    input  logic [udp_cmd_pkg::BYTE_W-1:0]        rx_tdata,
    input  logic                                  rx_tvalid,
    output logic                                  rx_tready,
    input  logic                                  rx_tlast,
    output logic                                  tx_hdr_valid,
    input  logic                                  tx_hdr_ready,
    output logic [udp_cmd_pkg::IP_W-1:0]          tx_src_ip,
    output logic [udp_cmd_pkg::IP_W-1:0]          tx_dest_ip,
    output logic [udp_cmd_pkg::PORT_W-1:0]        tx_src_port,
    output logic [udp_cmd_pkg::PORT_W-1:0]        tx_dest_port,
    output logic [udp_cmd_pkg::PORT_W-1:0]        tx_length,
    output logic [udp_cmd_pkg::BYTE_W-1:0]        tx_tdata,
    output logic                                  tx_tvalid,
    input  logic                                  tx_tready,
    output logic                                  tx_tlast,
    output logic                                  wb_cyc,
    output logic                                  wb_stb,
    output logic [udp_cmd_pkg::FLASH_ADR_W-1:0]   wb_adr,
    input  logic [udp_cmd_pkg::BYTE_W-1:0]        wb_dat_i,
    input  logic                                  wb_ack
);

    cmd_if   cmd_bus ();
    reply_if reply_bus ();

    cmd_decode decode0 (
        .clk          (clk),
        .rst          (rst),
        .local_ip     (local_ip),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_src_ip    (rx_src_ip),
        .rx_src_port  (rx_src_port),
        .rx_dest_port (rx_dest_port),
        .rx_length    (rx_length),
        .cmd          (cmd_bus.source)
    );

    cmd_execute execute0 (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd_bus.sink),
        .rx_tdata  (rx_tdata),
        .rx_tvalid (rx_tvalid),
        .rx_tlast  (rx_tlast),
        .rx_tready (rx_tready),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack),
        .reply     (reply_bus.source)
    );

    reply_result result0 (
        .clk          (clk),
        .rst          (rst),
        .reply        (reply_bus.sink),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_src_ip    (tx_src_ip),
        .tx_dest_ip   (tx_dest_ip),
        .tx_src_port  (tx_src_port),
        .tx_dest_port (tx_dest_port),
        .tx_length    (tx_length),
        .tx_tdata     (tx_tdata),
        .tx_tvalid    (tx_tvalid),
        .tx_tready    (tx_tready),
        .tx_tlast     (tx_tlast)
    );

endmodule

// ==== testbench/udp_cmd_model.svh ====
`ifndef UDP_CMD_MODEL_SVH
`define UDP_CMD_MODEL_SVH

// Reply header as it appears on the tx header ports
typedef struct packed {
    logic [udp_cmd_pkg::IP_W-1:0]   src_ip;
    logic [udp_cmd_pkg::IP_W-1:0]   dest_ip;
    logic [udp_cmd_pkg::PORT_W-1:0] src_port;
    logic [udp_cmd_pkg::PORT_W-1:0] dest_port;
    logic [udp_cmd_pkg::PORT_W-1:0] length;
} reply_hdr_t;

reply_hdr_t exp_hdr_q[$];
// Expected payload beats as {last, data}
logic [8:0] exp_byte_q[$];
// Flash addresses in the order they should be read
logic [23:0] exp_adr_q[$];

// Datagram currently being sent
logic [udp_cmd_pkg::PORT_W-1:0]      dg_dest_port;
logic [udp_cmd_pkg::PORT_W-1:0]      dg_src_port;
logic [udp_cmd_pkg::IP_W-1:0]        dg_src_ip;
logic [udp_cmd_pkg::FLASH_ADR_W-1:0] dg_addr;
logic [udp_cmd_pkg::BYTE_W-1:0]      dg_pay [0:19];
int                                  dg_len;

// Flash content: XOR of the three address bytes
function automatic logic [7:0] flash_byte(input logic [23:0] adr);
    return adr[23:16] ^ adr[15:8] ^ adr[7:0];
endfunction

task automatic make_datagram(input logic [15:0] dest_port, input int min_len,
                             input int max_len);
    int i;
    dg_dest_port = dest_port;
    dg_src_port  = 16'($random(seed));
    dg_src_ip    = $random(seed);
    dg_len       = min_len + int'({$random(seed)} % (max_len - min_len + 1));
    for (i = 0; i < 20; i++) begin
        dg_pay[i] = 8'($random(seed));
    end
    // Address travels least significant byte first
    dg_addr = {dg_pay[2], dg_pay[1], dg_pay[0]};
endtask

task automatic expect_reply;
    reply_hdr_t  h;
    logic [23:0] a;
    int          i;
    h.src_ip  = LOCAL_IP;
    h.dest_ip = dg_src_ip;
    if (dg_dest_port == udp_cmd_pkg::PORT_ECHO ||
        dg_dest_port == udp_cmd_pkg::PORT_ECHO_FIXED) begin
        h.src_port  = udp_cmd_pkg::PORT_ECHO;
        h.dest_port = (dg_dest_port == udp_cmd_pkg::PORT_ECHO) ? dg_src_port
                                                                : udp_cmd_pkg::PORT_ECHO;
        h.length    = 16'(dg_len) + udp_cmd_pkg::HDR_LEN;
        exp_hdr_q.push_back(h);
        for (i = 0; i < dg_len; i++) begin
            exp_byte_q.push_back({i == dg_len - 1, dg_pay[i]});
        end
    end else if (dg_dest_port == udp_cmd_pkg::PORT_RD_REQ) begin
        h.src_port  = udp_cmd_pkg::PORT_RD_REQ;
        h.dest_port = udp_cmd_pkg::PORT_RD_REPLY;
        h.length    = udp_cmd_pkg::READ_LEN + udp_cmd_pkg::HDR_LEN;
        exp_hdr_q.push_back(h);
        a = dg_addr;
        for (i = 0; i < int'(udp_cmd_pkg::READ_LEN); i++) begin
            exp_adr_q.push_back(a);
            exp_byte_q.push_back({i == int'(udp_cmd_pkg::READ_LEN) - 1, flash_byte(a)});
            a = a + 24'd1;
        end
    end
endtask

// Wishbone slave, called once per falling edge
task automatic respond_flash;
    if (wb_ack) begin
        wb_ack   = 1'b0;
        ack_wait = int'({$random(seed)} % 4);
    end else if (wb_cyc && wb_stb) begin
        if (ack_wait == 0) begin
            wb_ack   = 1'b1;
            wb_dat_i = flash_byte(wb_adr);
            if (exp_adr_q.size() == 0) begin
                report_failure("Wishbone read started with no flash read expected");
            end else begin
                check("wb_adr", exp_adr_q.pop_front(), wb_adr);
            end
        end else begin
            ack_wait = ack_wait - 1;
        end
    end
endtask

`endif

// ==== testbench/tb_udp_cmd.sv ====
`timescale 1ns/1ps

module tb_udp_cmd;

    localparam logic [31:0] LOCAL_IP   = 32'hc0a8_0164;
    localparam int          MIX_COUNT  = 80;
    localparam int          WAIT_LIMIT = 2000;

    logic        clk;
    logic        rst;
    logic [31:0] local_ip;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    logic [31:0] rx_src_ip;
    logic [15:0] rx_src_port;
    logic [15:0] rx_dest_port;
    logic [15:0] rx_length;
    logic [7:0]  rx_tdata;
    logic        rx_tvalid;
    logic        rx_tready;
    logic        rx_tlast;
    logic        tx_hdr_valid;
    logic        tx_hdr_ready;
    logic [31:0] tx_src_ip;
    logic [31:0] tx_dest_ip;
    logic [15:0] tx_src_port;
    logic [15:0] tx_dest_port;
    logic [15:0] tx_length;
    logic [7:0]  tx_tdata;
    logic        tx_tvalid;
    logic        tx_tready;
    logic        tx_tlast;
    logic        wb_cyc;
    logic        wb_stb;
    logic [23:0] wb_adr;
    logic [7:0]  wb_dat_i;
    logic        wb_ack;

    integer seed;
    int     mismatch_count;
    int     other_count;
    int     ack_wait;
    int     n;
    logic   aborted;
    logic   stall_on;
    logic   hdr_fire;
    logic   beat_fire;
    logic   prev_cyc;
    logic   prev_stall;

    `include "udp_cmd_model.svh"

    udp_cmd_top dut0 (.*);

    always #20 clk = ~clk;

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        other_count++;
        $display("%0t: %s", $time, what);
    endtask

    task automatic check_header;
        reply_hdr_t h;
        if (exp_hdr_q.size() == 0) begin
            report_failure("reply header appeared on the tx ports with none expected");
        end else begin
            h = exp_hdr_q.pop_front();
            check("tx_src_ip", h.src_ip, tx_src_ip);
            check("tx_dest_ip", h.dest_ip, tx_dest_ip);
            check("tx_src_port", h.src_port, tx_src_port);
            check("tx_dest_port", h.dest_port, tx_dest_port);
            check("tx_length", h.length, tx_length);
        end
    endtask

    task automatic check_byte;
        logic [8:0] e;
        if (exp_byte_q.size() == 0) begin
            report_failure("payload byte appeared on the tx ports with none expected");
        end else begin
            e = exp_byte_q.pop_front();
            check("tx_tdata", e[7:0], tx_tdata);
            check("tx_tlast", e[8], tx_tlast);
        end
    endtask

    // Transfers are sampled like a flop, then read by the stimulus on the falling edge
    always @(posedge clk) begin
        hdr_fire   <= rx_hdr_valid && rx_hdr_ready;
        beat_fire  <= rx_tvalid && rx_tready;
        prev_cyc   <= wb_cyc;
        prev_stall <= tx_tvalid && !tx_tready;
        if (!rst) begin
            if (tx_hdr_valid && tx_hdr_ready) begin
                check_header();
            end
            if (tx_tvalid && tx_tready) begin
                check_byte();
            end
            if (wb_cyc && !prev_cyc && prev_stall) begin
                report_failure("Wishbone cycle started while the tx payload was stalled");
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            tx_tready    = !stall_on || ({$random(seed)} % 4 != 0);
            tx_hdr_ready = !stall_on || ({$random(seed)} % 3 != 0);
            respond_flash();
        end
    end

    task automatic send_header;
        int wait_cycles;
        rx_hdr_valid = 1'b1;
        rx_src_ip    = dg_src_ip;
        rx_src_port  = dg_src_port;
        rx_dest_port = dg_dest_port;
        rx_length    = 16'(dg_len) + udp_cmd_pkg::HDR_LEN;
        wait_cycles  = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!hdr_fire && wait_cycles < WAIT_LIMIT);
        rx_hdr_valid = 1'b0;
        if (!hdr_fire) begin
            aborted = 1'b1;
            report_failure("timed out waiting for rx_hdr_ready");
        end
    endtask

    task automatic send_payload;
        int i;
        int wait_cycles;
        for (i = 0; i < dg_len && !aborted; i++) begin
            // Occasional idle cycle between bytes
            if ({$random(seed)} % 4 == 0) begin
                rx_tvalid = 1'b0;
                @(negedge clk);
            end
            rx_tvalid   = 1'b1;
            rx_tdata    = dg_pay[i];
            rx_tlast    = (i == dg_len - 1);
            wait_cycles = 0;
            do begin
                @(negedge clk);
                wait_cycles++;
            end while (!beat_fire && wait_cycles < WAIT_LIMIT);
            if (!beat_fire) begin
                aborted = 1'b1;
                report_failure("timed out waiting for rx_tready");
            end
        end
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
    endtask

    task automatic run_datagram(input logic [15:0] port, input int min_len, input int max_len);
        if (!aborted) begin
            make_datagram(port, min_len, max_len);
            expect_reply();
            send_header();
            send_payload();
        end
    endtask

    task automatic wait_drain;
        int wait_cycles;
        wait_cycles = 0;
        while (!aborted && (exp_hdr_q.size() != 0 || exp_byte_q.size() != 0)
               && wait_cycles < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (exp_hdr_q.size() != 0 || exp_byte_q.size() != 0) begin
            report_failure("timed out waiting for the expected replies");
        end
        // Quiet period to catch any extra reply
        repeat (20) @(negedge clk);
    endtask

    initial begin
        seed           = 32'hf275_36c0;
        mismatch_count = 0;
        other_count    = 0;
        ack_wait       = 0;
        aborted        = 1'b0;
        stall_on       = 1'b0;
        clk            = 1'b0;
        rst            = 1'b1;
        local_ip       = LOCAL_IP;
        rx_hdr_valid   = 1'b0;
        rx_src_ip      = '0;
        rx_src_port    = '0;
        rx_dest_port   = '0;
        rx_length      = '0;
        rx_tdata       = '0;
        rx_tvalid      = 1'b0;
        rx_tlast       = 1'b0;
        tx_hdr_ready   = 1'b1;
        tx_tready      = 1'b1;
        wb_dat_i       = '0;
        wb_ack         = 1'b0;
        repeat (16) @(negedge clk);
        check("rx_hdr_ready", 0, rx_hdr_ready);
        check("rx_tready", 0, rx_tready);
        check("tx_hdr_valid", 0, tx_hdr_valid);
        check("tx_tvalid", 0, tx_tvalid);
        check("wb_cyc", 0, wb_cyc);
        check("wb_stb", 0, wb_stb);
        rst = 1'b0;

        // Directed commands, no back-pressure
        run_datagram(udp_cmd_pkg::PORT_ECHO, 1, 20);
        run_datagram(udp_cmd_pkg::PORT_ECHO_FIXED, 1, 20);
        run_datagram(udp_cmd_pkg::PORT_RD_REQ, 3, 3);
        run_datagram(udp_cmd_pkg::PORT_RD_REQ, 4, 20);
        run_datagram(16'd5000, 1, 20);
        run_datagram(udp_cmd_pkg::PORT_ECHO, 1, 20);
        wait_drain();

        // Random mix with tx stalls and slow acks
        stall_on = 1'b1;
        for (n = 0; n < MIX_COUNT && !aborted; n++) begin
            case ({$random(seed)} % 4)
                0:       run_datagram(udp_cmd_pkg::PORT_ECHO, 1, 20);
                1:       run_datagram(udp_cmd_pkg::PORT_ECHO_FIXED, 1, 20);
                2:       run_datagram(udp_cmd_pkg::PORT_RD_REQ, 3, 20);
                default: run_datagram(16'd2000 + 16'({$random(seed)} % 1000), 1, 20);
            endcase
        end
        wait_drain();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== udp_cmd_top.f ====
+incdir+testbench
hdl/udp_cmd_pkg.sv
hdl/udp_cmd_if.sv
hdl/cmd_decode.sv
hdl/cmd_execute.sv
hdl/reply_result.sv
hdl/udp_cmd_top.sv
testbench/tb_udp_cmd.sv
